// ==== build.f ====
+incdir+test
verilog/cart_pkg.sv
verilog/load_control.sv
verilog/region_header.sv
verilog/region_select.sv
verilog/cart_id_quirks.sv
verilog/cart_loader_top.sv
test/cart_loader_tb.sv

// ==== test/cart_loader_model.svh ====
// Cartridge loader reference model
`ifndef CART_LOADER_MODEL_SVH
`define CART_LOADER_MODEL_SVH

localparam int QUIRK_ENTRIES = 14;
localparam int SVP_ENTRY     = 6;

// Memory holds the image big endian
function automatic word_t swap_bytes(input word_t w);
	return {w[7:0], w[15:8]};
endfunction

function automatic region_flags_t letter_region(input logic [7:0] ch);
	region_flags_t f;
	f = '0;
	case (ch)
		"J": f.jp = 1'b1;
		"U": f.us = 1'b1;
		"E": f.eu = 1'b1;
		default: ;
	endcase
	return f;
endfunction

// Flags from header bytes 0x1F0, 0x1F1 and 0x1F2
function automatic region_flags_t header_flags(input logic [7:0] b0, input logic [7:0] b1,
		input logic [7:0] b2);
	region_flags_t f;
	logic [7:0]    v;
	logic          is_hex;
	f      = letter_region(b1) | letter_region(b2);
	v      = '0;
	is_hex = 1'b1;
	if (b0 >= "0" && b0 <= "9") begin
		v = b0 - "0";
	end else if (b0 >= "A" && b0 <= "F") begin
		v = b0 - "A" + 8'd10;
	end else begin
		is_hex = 1'b0;
	end
	if (letter_region(b0) != '0) begin
		f = f | letter_region(b0);  // Letter wins over hex reading of E
	end else if (is_hex) begin
		f.jp = f.jp | v[0];
		f.us = f.us | v[2];
		f.eu = f.eu | v[3];
	end
	return f;
endfunction

function automatic logic region_flagged(input region_flags_t f, input region_t r);
	return (r == REGION_JP && f.jp) || (r == REGION_US && f.us) || (r == REGION_EU && f.eu);
endfunction

function automatic region_t choose_region(input region_flags_t f, input region_prio_t prio);
	region_t order [3];
	region_t pick;
	logic    found;
	int      i;
	case (prio)
		PRIO_US_EU_JP: order = '{REGION_US, REGION_EU, REGION_JP};
		PRIO_EU_US_JP: order = '{REGION_EU, REGION_US, REGION_JP};
		PRIO_US_JP_EU: order = '{REGION_US, REGION_JP, REGION_EU};
		default:       order = '{REGION_JP, REGION_US, REGION_EU};
	endcase
	pick  = order[0];  // Nothing flagged
	found = 1'b0;
	for (i = 0; i < 3; i++) begin
		if (!found && region_flagged(f, order[i])) begin
			pick  = order[i];
			found = 1'b1;
		end
	end
	return pick;
endfunction

//////////////////////////////////////////////////
// Compatibility table

function automatic cart_id_t quirk_code(input int i);
	case (i)
		0:  return "T-081276";
		1:  return "T-81406 ";
		2:  return "MK-1215 ";
		3:  return "G-4060  ";
		4:  return "T-113016";
		5:  return "T-89016 ";
		6:  return "MK-1229 ";
		7:  return "G-7001  ";
		8:  return "T-35036 ";
		9:  return "MK-1533 ";
		10: return "T-95096-";
		11: return "T-95136-";
		12: return "MK-1658 ";
		default: return "T-081156";
	endcase
endfunction

// Bits are sram eeprom noram fifo svp fmbusy gun_type
function automatic quirk_flags_t quirk_flags(input int i);
	case (i)
		0, 1:   return 7'b1000000;
		2, 3:   return 7'b0100000;
		4:      return 7'b0010000;
		5:      return 7'b0001000;
		6, 7:   return 7'b0000100;
		8:      return 7'b0000010;
		10, 11: return 7'b0000001;
		default: return 7'b0000000;
	endcase
endfunction

function automatic gun_delay_t quirk_delay(input int i);
	case (i)
		9:  return 8'd100;
		10: return 8'd52;
		11: return 8'd30;
		12: return 8'd120;
		13: return 8'd126;
		default: return GUN_DELAY_DEFAULT;
	endcase
endfunction

function automatic void lookup_quirks(input cart_id_t code, output quirk_flags_t q,
		output gun_delay_t d);
	int i;
	q = '0;
	d = GUN_DELAY_DEFAULT;
	for (i = 0; i < QUIRK_ENTRIES; i++) begin
		if (code == quirk_code(i)) begin
			q = quirk_flags(i);
			d = quirk_delay(i);
		end
	end
endfunction

`endif

// ==== test/cart_loader_tb.sv ====
// Cartridge loader testbench
`default_nettype none

module cart_loader_tb;
	import cart_pkg::*;

	`include "cart_loader_model.svh"

	localparam int BK_BLOCKS   = 128;
	localparam int N_DOWNLOADS = 40;
	localparam int DL_CYCLES   = 6000;  // Worst case words, load and save
	localparam int CYCLE_LIMIT = N_DOWNLOADS * DL_CYCLES;
	localparam int IMG_BYTES   = 'h240;

	logic          clk_sys;
	logic          RESET;
	logic          cart_download;
	logic          ioctl_wr;
	ioctl_addr_t   ioctl_addr;
	word_t         ioctl_data;
	logic          ioctl_wait;
	rom_write_t    rom_write;
	logic          mem_wrack;
	ioctl_addr_t   rom_size;
	logic          auto_region_en;
	region_prio_t  region_priority;
	region_t       region;
	logic          region_set;
	quirk_flags_t  quirks;
	gun_delay_t    gun_sensor_delay;
	logic          img_mounted;
	logic          img_readonly;
	logic          img_size_nz;
	logic          bk_load;
	logic          bk_save;
	logic          sd_ack;
	sd_req_t       sd_req;
	logic          bk_loading;
	logic          bk_busy;

	int            error_count = 0;
	int            check_count = 0;
	int            cycle_count = 0;
	int unsigned   delay_pool [256];
	logic [7:0]    img [IMG_BYTES];
	rom_write_t    rom_expect [$];
	sd_req_t       sd_log [$];
	logic          exp_req = 1'b0;
	logic          seen_req = 1'b0;
	string         region_chars = "JUE 0123456789ABCDEF";
	string         letter_chars = "JUE ";

	cart_loader_top #(
		.BK_BLOCKS(BK_BLOCKS)
	) UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("Timeout after %0d cycles, the run did not finish", cycle_count);
		$display("Some tests failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Compare tasks

	task automatic check_rom_write(input rom_write_t got, input rom_write_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("error at time %0t: rom_write req %b addr %h data %h, expected %b %h %h",
				$time, got.req, got.addr, got.data, exp.req, exp.addr, exp.data);
		end
	endtask

	task automatic check_region(input region_t got, input region_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("error at time %0t: region %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_quirks(input quirk_flags_t got_q, input gun_delay_t got_d,
			input quirk_flags_t exp_q, input gun_delay_t exp_d);
		check_count++;
		if (got_q !== exp_q || got_d !== exp_d) begin
			error_count++;
			$display("error at time %0t: quirks %b delay %0d, expected %b delay %0d",
				$time, got_q, got_d, exp_q, exp_d);
		end
	endtask

	task automatic check_sd_req(input sd_req_t got, input sd_req_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("error at time %0t: sd_req lba %0d rd %b wr %b, expected %0d %b %b",
				$time, got.lba, got.rd, got.wr, exp.lba, exp.rd, exp.wr);
		end
	endtask

	task automatic check_addr(input string what, input ioctl_addr_t got, input ioctl_addr_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("error at time %0t: %s %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("error at time %0t: %s %b, expected %b", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// Memory and SD responders

	logic mem_pending = 1'b0;
	int   mem_cnt = 0;
	int   mem_idx = 0;

	always @(posedge clk_sys) begin
		if (RESET) begin
			mem_wrack   <= 1'b0;
			mem_pending <= 1'b0;
		end else if (mem_pending) begin
			if (mem_cnt == 0) begin
				mem_wrack   <= rom_write.req;  // Echo the toggle
				mem_pending <= 1'b0;
			end else begin
				mem_cnt <= mem_cnt - 1;
			end
		end else if (rom_write.req != mem_wrack) begin
			mem_pending <= 1'b1;
			mem_cnt     <= delay_pool[mem_idx % 256];
			mem_idx     <= mem_idx + 1;
		end
	end

	int sd_phase = 0;  // Idle, ack delay, ack high
	int sd_cnt = 0;
	int sd_idx = 0;

	always @(posedge clk_sys) begin
		if (RESET) begin
			sd_ack   <= 1'b0;
			sd_phase <= 0;
		end else begin
			case (sd_phase)
				0: begin
					if (sd_req.rd || sd_req.wr) begin
						sd_log.push_back(sd_req);
						sd_cnt   <= delay_pool[sd_idx % 256] % 4;
						sd_idx   <= sd_idx + 1;
						sd_phase <= 1;
					end
				end
				1: begin
					if (sd_cnt == 0) begin
						sd_ack   <= 1'b1;
						sd_cnt   <= delay_pool[(sd_idx + 128) % 256] % 4;
						sd_phase <= 2;
					end else begin
						sd_cnt <= sd_cnt - 1;
					end
				end
				default: begin
					if (sd_cnt == 0) begin
						sd_ack   <= 1'b0;  // Block done
						sd_phase <= 0;
					end else begin
						sd_cnt <= sd_cnt - 1;
					end
				end
			endcase
		end
	end

	// Every req toggle takes the oldest outstanding word
	always @(posedge clk_sys) begin
		if (!RESET && rom_write.req !== seen_req) begin
			seen_req <= rom_write.req;
			if (rom_expect.size() == 0) begin
				error_count++;
				$display("Memory write at time %0t with no word outstanding", $time);
			end else begin
				check_rom_write(rom_write, rom_expect.pop_front());
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus

	task automatic write_word(input ioctl_addr_t a, input word_t w);
		rom_write_t exp;
		exp_req = ~exp_req;
		exp     = '{req: exp_req, addr: rom_addr_t'(a >> 1), data: swap_bytes(w)};
		rom_expect.push_back(exp);
		ioctl_addr <= a;
		ioctl_data <= w;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		do begin
			@(posedge clk_sys);
		end while (ioctl_wait);
	endtask

	task automatic wait_backup_idle();
		while (bk_busy) begin
			@(posedge clk_sys);
		end
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic check_backup_log(input logic is_load, input int blocks);
		sd_req_t exp;
		int      i;
		if (sd_log.size() != blocks) begin
			error_count++;
			$display("Backup RAM at time %0t made %0d SD requests where %0d were due",
				$time, sd_log.size(), blocks);
		end
		for (i = 0; i < sd_log.size() && i < blocks; i++) begin
			exp = '{lba: lba_t'(i), rd: is_load, wr: !is_load};
			check_sd_req(sd_log[i], exp);
		end
		sd_log.delete();
		check_flag("bk_loading", bk_loading, 1'b0);
	endtask

	task automatic run_download(input int n);
		int           a;
		int           k;
		cart_id_t     code;
		quirk_flags_t exp_q;
		gun_delay_t   exp_d;
		ioctl_addr_t  last;
		logic         auto_en;
		region_prio_t prio;
		logic         mounted;
		logic         readonly;
		logic         size_nz;
		logic         bk_ok;
		logic         exp_load;

		for (a = 0; a < IMG_BYTES; a++) begin
			img[a] = 8'($urandom_range(0, 255));
		end
		if (n % 8 == 3) begin
			code = quirk_code(SVP_ENTRY);
		end else if ($urandom_range(0, 1) == 1) begin
			code = quirk_code($urandom_range(0, QUIRK_ENTRIES - 1));
		end else begin
			for (k = 0; k < 8; k++) begin
				code[63 - 8 * k -: 8] = 8'($urandom_range(33, 126));  // Printable
			end
		end
		for (k = 0; k < 8; k++) begin
			img[HDR_ID_FIRST + 1 + k] = code[63 - 8 * k -: 8];
		end
		img[HDR_REGION_ADDR]     = region_chars[$urandom_range(0, region_chars.len() - 1)];
		img[HDR_REGION_ADDR + 1] = letter_chars[$urandom_range(0, letter_chars.len() - 1)];
		img[HDR_REGION2_ADDR]    = letter_chars[$urandom_range(0, letter_chars.len() - 1)];
		lookup_quirks(code, exp_q, exp_d);

		auto_en  = ($urandom_range(0, 3) != 0);
		prio     = region_prio_t'($urandom_range(0, 3));
		mounted  = (n % 8 == 3) || ($urandom_range(0, 3) != 0);
		readonly = (n % 8 != 3) && ($urandom_range(0, 3) == 0);
		size_nz  = (n % 8 == 3) || ($urandom_range(0, 2) == 0);
		bk_ok    = mounted && !readonly && !exp_q.svp;
		exp_load = bk_ok && size_nz;

		auto_region_en  <= auto_en;
		region_priority <= prio;
		img_mounted     <= mounted;
		img_readonly    <= readonly;
		img_size_nz     <= size_nz;
		@(posedge clk_sys);
		cart_download <= 1'b1;
		repeat (3) @(posedge clk_sys);

		last = HDR_END_ADDR + ioctl_addr_t'(2 * $urandom_range(0, 15));
		for (a = 0; a <= last; a += 2) begin
			write_word(ioctl_addr_t'(a), {img[a + 1], img[a]});
		end
		repeat (2) @(posedge clk_sys);
		if (rom_expect.size() != 0) begin
			error_count++;
			$display("Download %0d lost %0d memory writes", n, rom_expect.size());
			rom_expect.delete();
		end
		check_flag("region_set", region_set, auto_en);
		if (auto_en) begin
			check_region(region, choose_region(header_flags(img[HDR_REGION_ADDR],
				img[HDR_REGION_ADDR + 1], img[HDR_REGION2_ADDR]), prio));
		end
		check_quirks(quirks, gun_sensor_delay, exp_q, exp_d);

		cart_download <= 1'b0;
		repeat (5) @(posedge clk_sys);
		check_addr("rom_size", rom_size, last);
		check_flag("bk_busy", bk_busy, exp_load);  // Automatic load after download
		check_flag("bk_loading", bk_loading, exp_load);
		wait_backup_idle();
		check_backup_log(1'b1, exp_load ? BK_BLOCKS : 0);

		if (n % 8 == 3 || $urandom_range(0, 3) == 0) begin
			bk_save <= 1'b1;
			@(posedge clk_sys);
			bk_save <= 1'b0;
			repeat (3) @(posedge clk_sys);
			check_flag("bk_busy", bk_busy, bk_ok);
			wait_backup_idle();
			check_backup_log(1'b0, bk_ok ? BK_BLOCKS : 0);
		end
	endtask

	initial begin
		int i;
		void'($urandom(65));
		for (i = 0; i < 256; i++) begin
			delay_pool[i] = $urandom_range(0, 5);
		end
		RESET           = 1'b1;
		cart_download   = 1'b0;
		ioctl_wr        = 1'b0;
		ioctl_addr      = '0;
		ioctl_data      = '0;
		mem_wrack       = 1'b0;
		auto_region_en  = 1'b0;
		region_priority = PRIO_US_EU_JP;
		img_mounted     = 1'b0;
		img_readonly    = 1'b0;
		img_size_nz     = 1'b0;
		bk_load         = 1'b0;
		bk_save         = 1'b0;
		sd_ack          = 1'b0;
		repeat (10) @(posedge clk_sys);
		RESET <= 1'b0;
		repeat (3) @(posedge clk_sys);
		check_flag("ioctl_wait", ioctl_wait, 1'b0);
		check_quirks(quirks, gun_sensor_delay, '0, GUN_DELAY_DEFAULT);

		for (i = 0; i < N_DOWNLOADS; i++) begin
			run_download(i);
		end

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/cart_id_quirks.sv ====
// Product code quirk lookup
`default_nettype none

module cart_id_quirks (
	input  wire                        clk_sys,
	input  wire                        RESET,
	input  wire                        cart_download,
	input  wire                        dl_start,
	input  wire                        ioctl_wr,
	input  wire cart_pkg::ioctl_addr_t ioctl_addr,
	input  wire cart_pkg::word_t       ioctl_data,
	output cart_pkg::quirk_flags_t     quirks,
	output cart_pkg::gun_delay_t       gun_sensor_delay
);
	import cart_pkg::*;

	logic         hdr_wr;
	cart_id_t     cart_id;
	quirk_flags_t id_quirks;
	gun_delay_t   id_delay;

	assign hdr_wr = cart_download & ioctl_wr;

	//////////////////////////////////////////////////
	// Code assembly, first character in the top byte

	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (ioctl_addr)
				HDR_ID_FIRST:          cart_id[63:56] <= ioctl_data[15:8];  // Odd start
				HDR_ID_FIRST + 25'd2:  cart_id[55:40] <= {ioctl_data[7:0], ioctl_data[15:8]};
				HDR_ID_FIRST + 25'd4:  cart_id[39:24] <= {ioctl_data[7:0], ioctl_data[15:8]};
				HDR_ID_FIRST + 25'd6:  cart_id[23:8]  <= {ioctl_data[7:0], ioctl_data[15:8]};
				HDR_ID_LAST:           cart_id[7:0]   <= ioctl_data[7:0];
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Compatibility table

	always_comb begin
		id_quirks = '0;
		id_delay  = GUN_DELAY_DEFAULT;
		case (cart_id)
			"T-081276": id_quirks.sram   = 1'b1;  // SRAM without header entry
			"T-81406 ": id_quirks.sram   = 1'b1;
			"MK-1215 ": id_quirks.eeprom = 1'b1;
			"G-4060  ": id_quirks.eeprom = 1'b1;
			"T-113016": id_quirks.noram  = 1'b1;  // Fake RAM check must fail
			"T-89016 ": id_quirks.fifo   = 1'b1;
			"MK-1229 ": id_quirks.svp    = 1'b1;
			"G-7001  ": id_quirks.svp    = 1'b1;
			"T-35036 ": id_quirks.fmbusy = 1'b1;
			// Light gun titles, sensor delay tuned per game
			"MK-1533 ": id_delay = 8'd100;
			"T-95096-": begin
				id_quirks.gun_type = 1'b1;
				id_delay           = 8'd52;
			end
			"T-95136-": begin
				id_quirks.gun_type = 1'b1;
				id_delay           = 8'd30;
			end
			"MK-1658 ": id_delay = 8'd120;
			"T-081156": id_delay = 8'd126;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			quirks           <= '0;
			gun_sensor_delay <= GUN_DELAY_DEFAULT;
		end else if (dl_start) begin
			quirks <= '0;
		end else if (hdr_wr && (ioctl_addr == HDR_ID_CHECK)) begin
			quirks           <= id_quirks;
			gun_sensor_delay <= id_delay;  // Default for any non-gun code
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cart_loader_top.sv ====
// Cartridge loader front end
`default_nettype none

module cart_loader_top #(
	parameter int BK_BLOCKS = 128  // Backup RAM size in SD blocks
) (
	input  wire                          clk_sys,
	input  wire                          RESET,

	// Loader side
	input  wire                          cart_download,
	input  wire                          ioctl_wr,
	input  wire cart_pkg::ioctl_addr_t   ioctl_addr,
	input  wire cart_pkg::word_t         ioctl_data,
	output logic                         ioctl_wait,

	// Cartridge memory
	output cart_pkg::rom_write_t         rom_write,
	input  wire                          mem_wrack,
	output cart_pkg::ioctl_addr_t        rom_size,

	// Region
	input  wire                          auto_region_en,
	input  wire cart_pkg::region_prio_t  region_priority,
	output cart_pkg::region_t            region,
	output logic                         region_set,

	// Compatibility
	output cart_pkg::quirk_flags_t       quirks,
	output cart_pkg::gun_delay_t         gun_sensor_delay,

	// Backup RAM image
	input  wire                          img_mounted,
	input  wire                          img_readonly,
	input  wire                          img_size_nz,
	input  wire                          bk_load,
	input  wire                          bk_save,
	input  wire                          sd_ack,
	output cart_pkg::sd_req_t            sd_req,
	output logic                         bk_loading,
	output logic                         bk_busy
);
	import cart_pkg::*;

	logic          dl_start;
	logic          dl_end;
	logic          hdr_ready;
	region_flags_t region_flags;

	load_control #(
		.BK_BLOCKS(BK_BLOCKS)
	) u_load_control (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_data    (ioctl_data),
		.mem_wrack     (mem_wrack),
		.svp_quirk     (quirks.svp),  // No backup RAM on SVP carts
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size_nz   (img_size_nz),
		.bk_load       (bk_load),
		.bk_save       (bk_save),
		.sd_ack        (sd_ack),
		.dl_start      (dl_start),
		.dl_end        (dl_end),
		.ioctl_wait    (ioctl_wait),
		.rom_write     (rom_write),
		.rom_size      (rom_size),
		.sd_req        (sd_req),
		.bk_loading    (bk_loading),
		.bk_busy       (bk_busy)
	);

	region_header u_region_header (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.dl_start      (dl_start),
		.dl_end        (dl_end),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_data    (ioctl_data),
		.flags         (region_flags),
		.hdr_ready     (hdr_ready)
	);

	region_select u_region_select (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.flags           (region_flags),
		.hdr_ready       (hdr_ready),
		.auto_region_en  (auto_region_en),
		.region_priority (region_priority),
		.region          (region),
		.region_set      (region_set)
	);

	cart_id_quirks u_cart_id_quirks (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.cart_download    (cart_download),
		.dl_start         (dl_start),
		.ioctl_wr         (ioctl_wr),
		.ioctl_addr       (ioctl_addr),
		.ioctl_data       (ioctl_data),
		.quirks           (quirks),
		.gun_sensor_delay (gun_sensor_delay)
	);

endmodule

`default_nettype wire

// ==== verilog/cart_pkg.sv ====
// Cartridge loader shared types
`default_nettype none

package cart_pkg;

	//////////////////////////////////////////////////
	// Widths with a meaning
	typedef logic [24:0] ioctl_addr_t;  // Download byte address
	typedef logic [15:0] word_t;
	typedef logic [23:0] rom_addr_t;    // Memory word address
	typedef logic [31:0] lba_t;
	typedef logic [63:0] cart_id_t;     // Eight ASCII characters
	typedef logic [7:0]  gun_delay_t;

	//////////////////////////////////////////////////
	// Enums
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	// First region in the name wins when several are flagged
	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} region_prio_t;

	typedef enum logic [1:0] {
		BK_IDLE = 2'd0,
		BK_REQ  = 2'd1,  // Waiting for SD ack
		BK_XFER = 2'd2   // Block moving, waiting for ack to drop
	} bk_state_t;

	//////////////////////////////////////////////////
	// Bundles
	typedef struct packed {
		logic jp;
		logic us;
		logic eu;
	} region_flags_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic svp;
		logic fmbusy;
		logic gun_type;  // 1 for the Justifier style gun
	} quirk_flags_t;

	typedef struct packed {
		logic      req;   // Toggles once per write
		rom_addr_t addr;
		word_t     data;  // Already byte swapped
	} rom_write_t;

	typedef struct packed {
		lba_t lba;
		logic rd;
		logic wr;
	} sd_req_t;

	// Header byte addresses
	localparam ioctl_addr_t HDR_ID_FIRST     = 25'h182;
	localparam ioctl_addr_t HDR_ID_LAST      = 25'h18A;
	localparam ioctl_addr_t HDR_ID_CHECK     = 25'h18C;  // Code complete here
	localparam ioctl_addr_t HDR_REGION_ADDR  = 25'h1F0;
	localparam ioctl_addr_t HDR_REGION2_ADDR = 25'h1F2;
	localparam ioctl_addr_t HDR_END_ADDR     = 25'h200;

	localparam gun_delay_t GUN_DELAY_DEFAULT = 8'd44;

endpackage

`default_nettype wire

// ==== verilog/load_control.sv ====
// Download and backup RAM control
`default_nettype none

module load_control #(
	parameter int BK_BLOCKS = 128
) (
	input  wire                        clk_sys,
	input  wire                        RESET,
	input  wire                        cart_download,
	input  wire                        ioctl_wr,
	input  wire cart_pkg::ioctl_addr_t ioctl_addr,
	input  wire cart_pkg::word_t       ioctl_data,
	input  wire                        mem_wrack,
	input  wire                        svp_quirk,
	input  wire                        img_mounted,
	input  wire                        img_readonly,
	input  wire                        img_size_nz,
	input  wire                        bk_load,
	input  wire                        bk_save,
	input  wire                        sd_ack,
	output logic                       dl_start,
	output logic                       dl_end,
	output logic                       ioctl_wait,
	output cart_pkg::rom_write_t       rom_write,
	output cart_pkg::ioctl_addr_t      rom_size,
	output cart_pkg::sd_req_t          sd_req,
	output logic                       bk_loading,
	output logic                       bk_busy
);
	import cart_pkg::*;

	logic      old_download;
	logic      old_load;
	logic      old_save;
	logic      old_ack;
	logic      load_edge;
	logic      save_edge;
	logic      last_block;
	logic      bk_ena;      // Writable image for this cart
	logic      wr_req;
	rom_addr_t wr_addr;
	word_t     wr_data;
	lba_t      sd_lba;
	logic      sd_rd;
	logic      sd_wr;
	bk_state_t bk_state;

	//////////////////////////////////////////////////
	// Download edges and ROM writes

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			dl_start     <= 1'b0;
			dl_end       <= 1'b0;
		end else begin
			old_download <= cart_download;
			dl_start     <= cart_download & ~old_download;
			dl_end       <= old_download & ~cart_download;
		end
	end

	// One write in flight, wait held until memory echoes the toggle
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			wr_req     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else if (cart_download && ioctl_wr) begin
			wr_req     <= ~wr_req;
			ioctl_wait <= 1'b1;
		end else if (ioctl_wait && (wr_req == mem_wrack)) begin
			ioctl_wait <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_download && ioctl_wr) begin
			wr_addr <= ioctl_addr[24:1];
			wr_data <= {ioctl_data[7:0], ioctl_data[15:8]};  // Big endian cart image
		end
		if (old_download && !cart_download) begin
			rom_size <= ioctl_addr;
		end
	end

	assign rom_write = '{req: wr_req, addr: wr_addr, data: wr_data};

	//////////////////////////////////////////////////
	// Backup RAM sequencer

	assign load_edge  = bk_load & ~old_load;
	assign save_edge  = bk_save & ~old_save;
	assign last_block = (sd_lba == lba_t'(BK_BLOCKS - 1));

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
			bk_ena   <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_ack  <= sd_ack;
			if (dl_start) begin
				bk_ena <= 1'b0;
			end else if (cart_download) begin
				bk_ena <= img_mounted & ~img_readonly & ~svp_quirk;  // Settles once header is read
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_state   <= BK_IDLE;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			case (bk_state)
				BK_IDLE: begin
					// Automatic load after a download beats a manual request
					if (bk_ena && dl_end && img_size_nz) begin
						bk_state   <= BK_REQ;
						bk_loading <= 1'b1;
						sd_lba     <= '0;
						sd_rd      <= 1'b1;
						sd_wr      <= 1'b0;
					end else if (bk_ena && (load_edge || save_edge)) begin
						bk_state   <= BK_REQ;
						bk_loading <= load_edge;
						sd_lba     <= '0;
						sd_rd      <= load_edge;
						sd_wr      <= ~load_edge;
					end
				end
				BK_REQ: begin
					if (sd_ack && !old_ack) begin
						sd_rd    <= 1'b0;
						sd_wr    <= 1'b0;
						bk_state <= BK_XFER;
					end
				end
				BK_XFER: begin
					if (old_ack && !sd_ack) begin
						if (last_block) begin
							bk_state   <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_lba   <= sd_lba + 1'b1;
							sd_rd    <= bk_loading;
							sd_wr    <= ~bk_loading;
							bk_state <= BK_REQ;
						end
					end
				end
				default: bk_state <= BK_IDLE;
			endcase
		end
	end

	assign sd_req  = '{lba: sd_lba, rd: sd_rd, wr: sd_wr};
	assign bk_busy = (bk_state != BK_IDLE);

	// Loader honours back-pressure
	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		ioctl_wait |-> !ioctl_wr);

	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_req.rd && sd_req.wr));

endmodule

`default_nettype wire

// ==== verilog/region_header.sv ====
// Header region scanner
`default_nettype none

module region_header (
	input  wire                        clk_sys,
	input  wire                        RESET,
	input  wire                        cart_download,
	input  wire                        dl_start,
	input  wire                        dl_end,
	input  wire                        ioctl_wr,
	input  wire cart_pkg::ioctl_addr_t ioctl_addr,
	input  wire cart_pkg::word_t       ioctl_data,
	output cart_pkg::region_flags_t    flags,
	output logic                       hdr_ready
);
	import cart_pkg::*;

	logic          hdr_wr;
	logic [7:0]    lo_byte;
	logic [7:0]    hi_byte;
	logic          lo_digit;
	logic          lo_hexl;
	logic [3:0]    hex_nib;
	region_flags_t lo_letter;
	region_flags_t hi_letter;
	region_flags_t hex_flags;

	// J, U or E mark one region, anything else none
	function automatic region_flags_t letter_flags(input logic [7:0] ch);
		region_flags_t f;
		f    = '0;
		f.jp = (ch == "J");
		f.us = (ch == "U");
		f.eu = (ch == "E");
		return f;
	endfunction

	assign hdr_wr    = cart_download & ioctl_wr;
	assign lo_byte   = ioctl_data[7:0];
	assign hi_byte   = ioctl_data[15:8];
	assign lo_letter = letter_flags(lo_byte);
	assign hi_letter = letter_flags(hi_byte);

	// Newer carts give a hex digit, one bit per region
	assign lo_digit  = (lo_byte >= "0") && (lo_byte <= "9");
	assign lo_hexl   = (lo_byte >= "A") && (lo_byte <= "F");
	assign hex_nib   = lo_digit ? lo_byte[3:0] : lo_byte[3:0] - 4'd7;  // 'A' low nibble 1 -> 10
	assign hex_flags = '{jp: hex_nib[0], us: hex_nib[2], eu: hex_nib[3]};

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			flags     <= '0;
			hdr_ready <= 1'b0;
		end else begin
			if (dl_start) begin
				flags <= '0;
			end
			if (dl_end) begin
				hdr_ready <= 1'b0;
			end
			if (hdr_wr) begin
				if (ioctl_addr == HDR_REGION_ADDR) begin
					if (lo_letter != '0) begin
						flags <= flags | lo_letter | hi_letter;
					end else if (lo_digit || lo_hexl) begin
						flags <= hex_flags | hi_letter;  // Digit replaces earlier flags
					end else begin
						flags <= flags | hi_letter;
					end
				end
				if (ioctl_addr == HDR_REGION2_ADDR) begin
					flags <= flags | lo_letter;
				end
				if (ioctl_addr == HDR_END_ADDR) begin
					hdr_ready <= 1'b1;  // Whole header seen
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/region_select.sv ====
// Console region choice
`default_nettype none

module region_select (
	input  wire                           clk_sys,
	input  wire                           RESET,
	input  wire cart_pkg::region_flags_t  flags,
	input  wire                           hdr_ready,
	input  wire                           auto_region_en,
	input  wire cart_pkg::region_prio_t   region_priority,
	output cart_pkg::region_t             region,
	output logic                          region_set
);
	import cart_pkg::*;

	logic old_ready;

	// First flagged region in the order, else the order's first
	function automatic region_t pick_region(input region_flags_t f, input region_prio_t prio);
		region_t pick;
		case (prio)
			PRIO_US_EU_JP: pick = f.us ? REGION_US : f.eu ? REGION_EU : f.jp ? REGION_JP : REGION_US;
			PRIO_EU_US_JP: pick = f.eu ? REGION_EU : f.us ? REGION_US : f.jp ? REGION_JP : REGION_EU;
			PRIO_US_JP_EU: pick = f.us ? REGION_US : f.jp ? REGION_JP : f.eu ? REGION_EU : REGION_US;
			default:       pick = f.jp ? REGION_JP : f.us ? REGION_US : f.eu ? REGION_EU : REGION_JP;
		endcase
		return pick;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_ready  <= 1'b0;
			region     <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			old_ready <= hdr_ready;
			if (hdr_ready && !old_ready && auto_region_en) begin
				region     <= pick_region(flags, region_priority);
				region_set <= 1'b1;
			end else if (!hdr_ready && old_ready) begin
				region_set <= 1'b0;  // Released at end of download
			end
		end
	end

endmodule

`default_nettype wire
